// ==== hw/pipe_pkg.sv ====
package pipe_pkg;

  // datapath widths
  localparam int XLEN          = 32;
  localparam int INST_LEN      = 32;
  localparam int REG_ADDRWIDTH = 5;

  // stall and flush vector layout, bit 3 kept for fetch
  localparam int CTRL_LEN   = 4;
  localparam int CTRL_IF_ID = 0;
  localparam int CTRL_ID_EX = 1;
  localparam int CTRL_EX_WB = 2;

  // addi x0, x0, 0
  localparam logic [INST_LEN-1:0] INST_NOP = 32'h0000_0013;

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  typedef enum logic [3:0] {
    ALU_NONE = 4'd0,
    ALU_ADD  = 4'd1,
    ALU_SUB  = 4'd2,
    ALU_AND  = 4'd3,
    ALU_OR   = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SLT  = 4'd6,
    ALU_LUI  = 4'd7,
    ALU_BEQ  = 4'd8,
    ALU_BNE  = 4'd9,
    ALU_JAL  = 4'd10
  } alu_op_e;

endpackage

// ==== hw/regfile.sv ====
`timescale 1ns/100ps

module regfile (
  input  logic                               clk,
  input  logic                               arst_n_i,
  input  logic [pipe_pkg::REG_ADDRWIDTH-1:0] rs1_idx_i,
  input  logic [pipe_pkg::REG_ADDRWIDTH-1:0] rs2_idx_i,
  output logic [pipe_pkg::XLEN-1:0]          rs1_data_o,
  output logic [pipe_pkg::XLEN-1:0]          rs2_data_o,
  input  logic                               wen_i,
  input  logic [pipe_pkg::REG_ADDRWIDTH-1:0] rd_idx_i,
  input  logic [pipe_pkg::XLEN-1:0]          rd_data_i
);
  import pipe_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && (rd_idx_i != '0)) begin
      regs[rd_idx_i] <= rd_data_i;
    end
  end

  assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

endmodule

// ==== hw/id_stage.sv ====
`timescale 1ns/100ps

module id_stage (
  input  logic                               clk,
  input  logic                               arst_n_i,
  input  logic [pipe_pkg::CTRL_LEN-1:0]      stall_valid_i,
  input  logic [pipe_pkg::CTRL_LEN-1:0]      flush_valid_i,
  input  logic                               inst_valid_i,
  input  logic [pipe_pkg::INST_LEN-1:0]      inst_i,
  input  logic [pipe_pkg::XLEN-1:0]          pc_i,
  input  logic                               bpu_taken_i,
  output logic [pipe_pkg::REG_ADDRWIDTH-1:0] rs1_idx_o,
  output logic [pipe_pkg::REG_ADDRWIDTH-1:0] rs2_idx_o,
  input  logic [pipe_pkg::XLEN-1:0]          rs1_data_i,
  input  logic [pipe_pkg::XLEN-1:0]          rs2_data_i,
  input  logic                               ex_valid_i,
  input  logic [pipe_pkg::REG_ADDRWIDTH-1:0] ex_rd_idx_i,
  input  logic [pipe_pkg::XLEN-1:0]          ex_result_i,
  input  logic                               wb_valid_i,
  input  logic [pipe_pkg::REG_ADDRWIDTH-1:0] wb_rd_idx_i,
  input  logic [pipe_pkg::XLEN-1:0]          wb_data_i,
  output logic                               valid_o,
  output logic [pipe_pkg::XLEN-1:0]          pc_o,
  output logic [pipe_pkg::INST_LEN-1:0]      inst_data_o,
  output logic                               bpu_taken_o,
  output logic [pipe_pkg::REG_ADDRWIDTH-1:0] rd_idx_o,
  output logic [pipe_pkg::XLEN-1:0]          imm_data_o,
  output logic [pipe_pkg::XLEN-1:0]          rs1_data_o,
  output logic [pipe_pkg::XLEN-1:0]          rs2_data_o,
  output pipe_pkg::alu_op_e                  alu_op_o
);
  import pipe_pkg::*;

  logic [INST_LEN-1:0] inst;
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;

  // IF/ID register, hold on stall, bubble on flush
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o     <= 1'b0;
      pc_o        <= '0;
      inst_data_o <= INST_NOP;
      bpu_taken_o <= 1'b0;
    end else if (!stall_valid_i[CTRL_IF_ID]) begin
      if (flush_valid_i[CTRL_IF_ID]) begin
        valid_o     <= 1'b0;
        inst_data_o <= INST_NOP;
        bpu_taken_o <= 1'b0;
      end else begin
        valid_o     <= inst_valid_i;
        pc_o        <= pc_i;
        inst_data_o <= inst_valid_i ? inst_i : INST_NOP;
        bpu_taken_o <= inst_valid_i & bpu_taken_i;
      end
    end
  end

  assign inst      = inst_data_o;
  assign opcode    = inst[6:0];
  assign funct3    = inst[14:12];
  assign funct7    = inst[31:25];
  assign rs1_idx_o = inst[19:15];
  assign rs2_idx_o = inst[24:20];

  // decode, unknown encodings fall through as ALU_NONE with no rd
  always_comb begin
    alu_op_o   = ALU_NONE;
    rd_idx_o   = '0;
    imm_data_o = '0;
    case (opcode)
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          alu_op_o   = ALU_ADD;
          rd_idx_o   = inst[11:7];
          imm_data_o = {{20{inst[31]}}, inst[31:20]};
        end
      end
      OPC_OP: begin
        rd_idx_o = inst[11:7];
        case ({funct7, funct3})
          10'b0000000_000: alu_op_o = ALU_ADD;
          10'b0100000_000: alu_op_o = ALU_SUB;
          10'b0000000_111: alu_op_o = ALU_AND;
          10'b0000000_110: alu_op_o = ALU_OR;
          10'b0000000_100: alu_op_o = ALU_XOR;
          10'b0000000_010: alu_op_o = ALU_SLT;
          default:         rd_idx_o = '0;
        endcase
      end
      OPC_LUI: begin
        alu_op_o   = ALU_LUI;
        rd_idx_o   = inst[11:7];
        imm_data_o = {inst[31:12], 12'b0};
      end
      OPC_BRANCH: begin
        if (funct3 == 3'b000) begin
          alu_op_o = ALU_BEQ;
        end else if (funct3 == 3'b001) begin
          alu_op_o = ALU_BNE;
        end
        imm_data_o = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      OPC_JAL: begin
        alu_op_o   = ALU_JAL;
        rd_idx_o   = inst[11:7];
        imm_data_o = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: ;
    endcase
  end

  // youngest producer wins: ID/EX first, then EX/WB, then the register file
  function automatic logic [XLEN-1:0] fwd_operand(
    input logic [REG_ADDRWIDTH-1:0] idx,
    input logic [XLEN-1:0]          rf_data
  );
    if (ex_valid_i && (ex_rd_idx_i != '0) && (ex_rd_idx_i == idx)) begin
      return ex_result_i;
    end
    if (wb_valid_i && (wb_rd_idx_i != '0) && (wb_rd_idx_i == idx)) begin
      return wb_data_i;
    end
    return rf_data;
  endfunction

  always_comb begin
    rs1_data_o = fwd_operand(rs1_idx_o, rs1_data_i);
    rs2_data_o = fwd_operand(rs2_idx_o, rs2_data_i);
  end

endmodule

// ==== hw/id_ex_reg.sv ====
`timescale 1ns/100ps

module id_ex_reg (
  input  logic                               clk,
  input  logic                               arst_n_i,
  input  logic [pipe_pkg::CTRL_LEN-1:0]      stall_valid_i,
  input  logic [pipe_pkg::CTRL_LEN-1:0]      flush_valid_i,
  input  logic                               valid_id_ex_i,
  input  logic [pipe_pkg::XLEN-1:0]          pc_id_ex_i,
  input  logic [pipe_pkg::INST_LEN-1:0]      inst_data_id_ex_i,
  input  logic                               bpu_taken_id_ex_i,
  input  logic [pipe_pkg::REG_ADDRWIDTH-1:0] rd_idx_id_ex_i,
  input  logic [pipe_pkg::XLEN-1:0]          imm_data_id_ex_i,
  input  logic [pipe_pkg::XLEN-1:0]          rs1_data_id_ex_i,
  input  logic [pipe_pkg::XLEN-1:0]          rs2_data_id_ex_i,
  input  pipe_pkg::alu_op_e                  alu_op_id_ex_i,
  output logic                               valid_id_ex_o,
  output logic [pipe_pkg::XLEN-1:0]          pc_id_ex_o,
  output logic [pipe_pkg::INST_LEN-1:0]      inst_data_id_ex_o,
  output logic                               bpu_taken_id_ex_o,
  output logic [pipe_pkg::REG_ADDRWIDTH-1:0] rd_idx_id_ex_o,
  output logic [pipe_pkg::XLEN-1:0]          imm_data_id_ex_o,
  output logic [pipe_pkg::XLEN-1:0]          rs1_data_id_ex_o,
  output logic [pipe_pkg::XLEN-1:0]          rs2_data_id_ex_o,
  output pipe_pkg::alu_op_e                  alu_op_id_ex_o
);
  import pipe_pkg::*;

  logic reg_wen;
  logic reg_clr;

  assign reg_wen = !stall_valid_i[CTRL_ID_EX];
  assign reg_clr = flush_valid_i[CTRL_ID_EX];

  // every field returns to its reset value on flush
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_id_ex_o     <= 1'b0;
      pc_id_ex_o        <= '0;
      inst_data_id_ex_o <= INST_NOP;
      bpu_taken_id_ex_o <= 1'b0;
      rd_idx_id_ex_o    <= '0;
      imm_data_id_ex_o  <= '0;
      rs1_data_id_ex_o  <= '0;
      rs2_data_id_ex_o  <= '0;
      alu_op_id_ex_o    <= ALU_NONE;
    end else if (reg_wen) begin
      valid_id_ex_o     <= reg_clr ? 1'b0 : valid_id_ex_i;
      pc_id_ex_o        <= reg_clr ? '0 : pc_id_ex_i;
      inst_data_id_ex_o <= reg_clr ? INST_NOP : inst_data_id_ex_i;
      bpu_taken_id_ex_o <= reg_clr ? 1'b0 : bpu_taken_id_ex_i;
      rd_idx_id_ex_o    <= reg_clr ? '0 : rd_idx_id_ex_i;
      imm_data_id_ex_o  <= reg_clr ? '0 : imm_data_id_ex_i;
      rs1_data_id_ex_o  <= reg_clr ? '0 : rs1_data_id_ex_i;
      rs2_data_id_ex_o  <= reg_clr ? '0 : rs2_data_id_ex_i;
      alu_op_id_ex_o    <= reg_clr ? ALU_NONE : alu_op_id_ex_i;
    end
  end

endmodule

// ==== hw/ex_stage.sv ====
`timescale 1ns/100ps

module ex_stage (
  input  logic                               clk,
  input  logic                               arst_n_i,
  input  logic [pipe_pkg::CTRL_LEN-1:0]      stall_valid_i,
  input  logic [pipe_pkg::CTRL_LEN-1:0]      flush_valid_i,
  input  logic                               valid_i,
  input  logic [pipe_pkg::XLEN-1:0]          pc_i,
  input  logic [pipe_pkg::INST_LEN-1:0]      inst_data_i,
  input  logic                               bpu_taken_i,
  input  logic [pipe_pkg::REG_ADDRWIDTH-1:0] rd_idx_i,
  input  logic [pipe_pkg::XLEN-1:0]          imm_data_i,
  input  logic [pipe_pkg::XLEN-1:0]          rs1_data_i,
  input  logic [pipe_pkg::XLEN-1:0]          rs2_data_i,
  input  pipe_pkg::alu_op_e                  alu_op_i,
  output logic [pipe_pkg::XLEN-1:0]          ex_result_o,
  output logic                               redirect_valid_o,
  output logic [pipe_pkg::XLEN-1:0]          redirect_pc_o,
  output logic                               wb_valid_o,
  output logic [pipe_pkg::XLEN-1:0]          wb_pc_o,
  output logic [pipe_pkg::REG_ADDRWIDTH-1:0] wb_rd_o,
  output logic [pipe_pkg::XLEN-1:0]          wb_data_o
);
  import pipe_pkg::*;

  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] br_target;
  logic            taken;

  // opcode bit 5 separates register-register from immediate forms
  assign op_b      = inst_data_i[5] ? rs2_data_i : imm_data_i;
  assign pc_plus4  = pc_i + XLEN'(4);
  assign br_target = pc_i + imm_data_i;

  always_comb begin
    ex_result_o = '0;
    taken       = 1'b0;
    case (alu_op_i)
      ALU_ADD: ex_result_o = rs1_data_i + op_b;
      ALU_SUB: ex_result_o = rs1_data_i - rs2_data_i;
      ALU_AND: ex_result_o = rs1_data_i & op_b;
      ALU_OR:  ex_result_o = rs1_data_i | op_b;
      ALU_XOR: ex_result_o = rs1_data_i ^ op_b;
      ALU_SLT: ex_result_o = {{(XLEN-1){1'b0}}, $signed(rs1_data_i) < $signed(op_b)};
      ALU_LUI: ex_result_o = imm_data_i;
      ALU_BEQ: taken = (rs1_data_i == rs2_data_i);
      ALU_BNE: taken = (rs1_data_i != rs2_data_i);
      ALU_JAL: begin
        taken       = 1'b1;
        ex_result_o = pc_plus4;
      end
      default: ;
    endcase
  end

  // non-control ops count as not taken, so a stray prediction is repaired too
  assign redirect_valid_o = valid_i && (taken != bpu_taken_i);
  assign redirect_pc_o    = taken ? br_target : pc_plus4;

  // EX/WB register
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_o <= 1'b0;
      wb_pc_o    <= '0;
      wb_rd_o    <= '0;
      wb_data_o  <= '0;
    end else if (!stall_valid_i[CTRL_EX_WB]) begin
      if (flush_valid_i[CTRL_EX_WB]) begin
        wb_valid_o <= 1'b0;
        wb_rd_o    <= '0;
      end else begin
        wb_valid_o <= valid_i;
        wb_pc_o    <= pc_i;
        wb_rd_o    <= valid_i ? rd_idx_i : '0;
        wb_data_o  <= ex_result_o;
      end
    end
  end

endmodule

// ==== hw/pipe_ctrl.sv ====
`timescale 1ns/100ps

module pipe_ctrl (
  input  logic                          wb_stall_i,
  input  logic                          redirect_valid_i,
  output logic [pipe_pkg::CTRL_LEN-1:0] stall_valid_o,
  output logic [pipe_pkg::CTRL_LEN-1:0] flush_valid_o,
  output logic                          ready_o
);
  import pipe_pkg::*;

  logic redirect_go;

  // a redirect under back-pressure waits until the stall drops
  assign redirect_go = redirect_valid_i & ~wb_stall_i;

  // back-pressure freezes the whole pipe
  assign stall_valid_o = {CTRL_LEN{wb_stall_i}};

  always_comb begin
    flush_valid_o             = '0;
    flush_valid_o[CTRL_IF_ID] = redirect_go;
    flush_valid_o[CTRL_ID_EX] = redirect_go;
  end

  // wrong-path fetch is refused while the redirect is pending
  assign ready_o = ~wb_stall_i & ~redirect_valid_i;

endmodule

// ==== hw/core_pipe.sv ====
`timescale 1ns/100ps

module core_pipe (
  input  logic                               clk,
  input  logic                               arst_n_i,
  input  logic                               inst_valid_i,
  input  logic [pipe_pkg::INST_LEN-1:0]      inst_i,
  input  logic [pipe_pkg::XLEN-1:0]          pc_i,
  input  logic                               bpu_taken_i,
  output logic                               ready_o,
  output logic                               wb_valid_o,
  output logic [pipe_pkg::XLEN-1:0]          wb_pc_o,
  output logic [pipe_pkg::REG_ADDRWIDTH-1:0] wb_rd_o,
  output logic [pipe_pkg::XLEN-1:0]          wb_data_o,
  input  logic                               wb_stall_i,
  output logic                               redirect_valid_o,
  output logic [pipe_pkg::XLEN-1:0]          redirect_pc_o
);
  import pipe_pkg::*;

  logic [CTRL_LEN-1:0]      stall_valid;
  logic [CTRL_LEN-1:0]      flush_valid;
  logic [REG_ADDRWIDTH-1:0] rs1_idx;
  logic [REG_ADDRWIDTH-1:0] rs2_idx;
  logic [XLEN-1:0]          rf_rs1_data;
  logic [XLEN-1:0]          rf_rs2_data;
  logic [XLEN-1:0]          ex_result;
  logic                     rf_wen;

  // decode outputs
  logic                     id_valid;
  logic [XLEN-1:0]          id_pc;
  logic [INST_LEN-1:0]      id_inst;
  logic                     id_bpu_taken;
  logic [REG_ADDRWIDTH-1:0] id_rd_idx;
  logic [XLEN-1:0]          id_imm;
  logic [XLEN-1:0]          id_rs1_data;
  logic [XLEN-1:0]          id_rs2_data;
  alu_op_e                  id_alu_op;

  // ID/EX outputs
  logic                     ex_valid;
  logic [XLEN-1:0]          ex_pc;
  logic [INST_LEN-1:0]      ex_inst;
  logic                     ex_bpu_taken;
  logic [REG_ADDRWIDTH-1:0] ex_rd_idx;
  logic [XLEN-1:0]          ex_imm;
  logic [XLEN-1:0]          ex_rs1_data;
  logic [XLEN-1:0]          ex_rs2_data;
  alu_op_e                  ex_alu_op;

  // write only on the retiring edge
  assign rf_wen = wb_valid_o & ~wb_stall_i;

  pipe_ctrl u_pipe_ctrl (
    .wb_stall_i      (wb_stall_i),
    .redirect_valid_i(redirect_valid_o),
    .stall_valid_o   (stall_valid),
    .flush_valid_o   (flush_valid),
    .ready_o         (ready_o)
  );

  regfile u_regfile (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .rs1_idx_i (rs1_idx),
    .rs2_idx_i (rs2_idx),
    .rs1_data_o(rf_rs1_data),
    .rs2_data_o(rf_rs2_data),
    .wen_i     (rf_wen),
    .rd_idx_i  (wb_rd_o),
    .rd_data_i (wb_data_o)
  );

  id_stage u_id_stage (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .stall_valid_i(stall_valid),
    .flush_valid_i(flush_valid),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .bpu_taken_i  (bpu_taken_i),
    .rs1_idx_o    (rs1_idx),
    .rs2_idx_o    (rs2_idx),
    .rs1_data_i   (rf_rs1_data),
    .rs2_data_i   (rf_rs2_data),
    .ex_valid_i   (ex_valid),
    .ex_rd_idx_i  (ex_rd_idx),
    .ex_result_i  (ex_result),
    .wb_valid_i   (wb_valid_o),
    .wb_rd_idx_i  (wb_rd_o),
    .wb_data_i    (wb_data_o),
    .valid_o      (id_valid),
    .pc_o         (id_pc),
    .inst_data_o  (id_inst),
    .bpu_taken_o  (id_bpu_taken),
    .rd_idx_o     (id_rd_idx),
    .imm_data_o   (id_imm),
    .rs1_data_o   (id_rs1_data),
    .rs2_data_o   (id_rs2_data),
    .alu_op_o     (id_alu_op)
  );

  id_ex_reg u_id_ex_reg (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .stall_valid_i    (stall_valid),
    .flush_valid_i    (flush_valid),
    .valid_id_ex_i    (id_valid),
    .pc_id_ex_i       (id_pc),
    .inst_data_id_ex_i(id_inst),
    .bpu_taken_id_ex_i(id_bpu_taken),
    .rd_idx_id_ex_i   (id_rd_idx),
    .imm_data_id_ex_i (id_imm),
    .rs1_data_id_ex_i (id_rs1_data),
    .rs2_data_id_ex_i (id_rs2_data),
    .alu_op_id_ex_i   (id_alu_op),
    .valid_id_ex_o    (ex_valid),
    .pc_id_ex_o       (ex_pc),
    .inst_data_id_ex_o(ex_inst),
    .bpu_taken_id_ex_o(ex_bpu_taken),
    .rd_idx_id_ex_o   (ex_rd_idx),
    .imm_data_id_ex_o (ex_imm),
    .rs1_data_id_ex_o (ex_rs1_data),
    .rs2_data_id_ex_o (ex_rs2_data),
    .alu_op_id_ex_o   (ex_alu_op)
  );

  ex_stage u_ex_stage (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .stall_valid_i   (stall_valid),
    .flush_valid_i   (flush_valid),
    .valid_i         (ex_valid),
    .pc_i            (ex_pc),
    .inst_data_i     (ex_inst),
    .bpu_taken_i     (ex_bpu_taken),
    .rd_idx_i        (ex_rd_idx),
    .imm_data_i      (ex_imm),
    .rs1_data_i      (ex_rs1_data),
    .rs2_data_i      (ex_rs2_data),
    .alu_op_i        (ex_alu_op),
    .ex_result_o     (ex_result),
    .redirect_valid_o(redirect_valid_o),
    .redirect_pc_o   (redirect_pc_o),
    .wb_valid_o      (wb_valid_o),
    .wb_pc_o         (wb_pc_o),
    .wb_rd_o         (wb_rd_o),
    .wb_data_o       (wb_data_o)
  );

endmodule

// ==== test/core_pipe_chk.sv ====
`timescale 1ns/100ps

module core_pipe_chk (
  input logic                               clk,
  input logic                               arst_n_i,
  input logic                               wb_stall_i,
  input logic                               ready_i,
  input logic                               redirect_valid_i,
  input logic                               wb_valid_i,
  input logic [pipe_pkg::XLEN-1:0]          wb_pc_i,
  input logic [pipe_pkg::REG_ADDRWIDTH-1:0] wb_rd_i,
  input logic [pipe_pkg::XLEN-1:0]          wb_data_i
);

  // fetch refused under back-pressure
  a_stall_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
    wb_stall_i |-> !ready_i)
    else $error("ready_o high while wb_stall_i is high");

  a_redirect_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
    redirect_valid_i |-> !ready_i)
    else $error("ready_o high while redirect_valid_o is high");

  // retire side frozen while stalled
  a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    wb_stall_i |=> $stable(wb_valid_i) && $stable(wb_pc_i) && $stable(wb_rd_i)
      && $stable(wb_data_i))
    else $error("retire outputs changed under back-pressure");

  a_reset_idle: assert property (@(posedge clk)
    !arst_n_i |-> !wb_valid_i && !redirect_valid_i)
    else $error("wb_valid_o or redirect_valid_o active in reset");

endmodule

// ==== test/core_pipe_tb.sv ====
`timescale 1ns/100ps

module core_pipe_tb;

  localparam int PROG_WORDS = 64;
  localparam int RETIRE_TARGET = 400;
  localparam int IDLE_LIMIT = 100;

  logic        clk;
  logic        arst_n_i;
  logic        inst_valid_i;
  logic [31:0] inst_i;
  logic [31:0] pc_i;
  logic        bpu_taken_i;
  logic        ready_o;
  logic        wb_valid_o;
  logic [31:0] wb_pc_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_data_o;
  logic        wb_stall_i;
  logic        redirect_valid_o;
  logic [31:0] redirect_pc_o;

  int          seed;
  logic [31:0] prog [0:PROG_WORDS-1];
  logic [31:0] model_regs [0:31];
  logic [31:0] model_pc;
  logic        pred_q [$];
  logic        pend_redirect;
  logic [31:0] pend_pc;

  core_pipe core_pipe_i (.*);

  bind core_pipe core_pipe_chk chk_i (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .wb_stall_i      (wb_stall_i),
    .ready_i         (ready_o),
    .redirect_valid_i(redirect_valid_o),
    .wb_valid_i      (wb_valid_o),
    .wb_pc_i         (wb_pc_o),
    .wb_rd_i         (wb_rd_o),
    .wb_data_i       (wb_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function int rand_below(input int n);
    rand_below = int'($unsigned($random(seed)) % $unsigned(n));
  endfunction

  function automatic logic [31:0] branch_offset(input logic [31:0] inst);
    return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] jump_offset(input logic [31:0] inst);
    return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

  // next fetch pc as the front end would guess it
  function automatic logic [31:0] predicted_next(
    input logic [31:0] inst,
    input logic [31:0] pc,
    input logic        taken
  );
    if (taken && inst[6:0] == 7'h63) begin
      return pc + branch_offset(inst);
    end
    if (taken && inst[6:0] == 7'h6f) begin
      return pc + jump_offset(inst);
    end
    return pc + 32'd4;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic build_program();
    int          kind;
    int          tgt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [12:0] boff;
    logic [20:0] joff;
    logic [11:0] imm;
    for (int i = 0; i < PROG_WORDS - 1; i++) begin
      kind = rand_below(12);
      rd   = 5'(rand_below(8));
      rs1  = 5'(rand_below(8));
      rs2  = 5'(rand_below(8));
      imm  = 12'(rand_below(4096));
      // forward targets only, so every pass ends at the last word
      tgt  = i + 1 + rand_below(PROG_WORDS - 1 - i);
      boff = 13'((tgt - i) * 4);
      joff = 21'((tgt - i) * 4);
      case (kind)
        0, 1: prog[i] = {imm, rs1, 3'b000, rd, 7'h13};
        2: prog[i] = {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
        3: prog[i] = {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
        4: prog[i] = {7'h00, rs2, rs1, 3'b111, rd, 7'h33};
        5: prog[i] = {7'h00, rs2, rs1, 3'b110, rd, 7'h33};
        6: prog[i] = {7'h00, rs2, rs1, 3'b100, rd, 7'h33};
        7: prog[i] = {7'h00, rs2, rs1, 3'b010, rd, 7'h33};
        8: prog[i] = {imm, 8'(rand_below(256)), rd, 7'h37};
        9, 10: prog[i] = {boff[12], boff[10:5], rs2, rs1, 3'(kind - 9), boff[4:1],
                          boff[11], 7'h63};
        default: prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'h6f};
      endcase
    end
    // jal x0 back to word 0
    joff = 21'(-(PROG_WORDS - 1) * 4);
    prog[PROG_WORDS-1] = {joff[20], joff[10:1], joff[11], joff[19:12], 5'd0, 7'h6f};
  endtask

  task automatic check_retire(
    input logic [31:0] pc,
    input logic [4:0]  rd,
    input logic [31:0] data
  );
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_data;
    logic [31:0] next_pc;
    logic        pred;
    logic        exp_taken;
    logic [4:0]  exp_rd;
    inst      = prog[model_pc[7:2]];
    a         = model_regs[inst[19:15]];
    b         = model_regs[inst[24:20]];
    exp_data  = '0;
    exp_rd    = '0;
    exp_taken = 1'b0;
    next_pc   = model_pc + 32'd4;
    case (inst[6:0])
      7'h13: begin
        exp_rd   = inst[11:7];
        exp_data = a + {{20{inst[31]}}, inst[31:20]};
      end
      7'h33: begin
        exp_rd = inst[11:7];
        case ({inst[30], inst[14:12]})
          4'b0000: exp_data = a + b;
          4'b1000: exp_data = a - b;
          4'b0111: exp_data = a & b;
          4'b0110: exp_data = a | b;
          4'b0100: exp_data = a ^ b;
          default: exp_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
      end
      7'h37: begin
        exp_rd   = inst[11:7];
        exp_data = {inst[31:12], 12'b0};
      end
      7'h63: begin
        if ((inst[12] == 1'b0) == (a == b)) begin
          exp_taken = 1'b1;
          next_pc   = model_pc + branch_offset(inst);
        end
      end
      default: begin
        exp_rd    = inst[11:7];
        exp_data  = model_pc + 32'd4;
        exp_taken = 1'b1;
        next_pc   = model_pc + jump_offset(inst);
      end
    endcase

    assert (pc == model_pc)
      else abort_run($sformatf("Fail at %0t: retired pc %h, expected %h", $time, pc, model_pc));
    assert (rd == exp_rd)
      else abort_run($sformatf("Fail at %0t: pc %h rd %0d, expected %0d", $time, pc, rd, exp_rd));
    assert (exp_rd == 5'd0 || data == exp_data)
      else abort_run($sformatf("Fail at %0t: pc %h data %h, expected %h",
                               $time, pc, data, exp_data));
    assert (pred_q.size() > 0)
      else abort_run("a retirement arrived for an instruction that was never accepted");
    pred = pred_q.pop_front();
    assert ((pred != exp_taken) == pend_redirect)
      else abort_run($sformatf("Fail at %0t: pc %h redirect %0b, mispredict %0b",
                               $time, pc, pend_redirect, pred != exp_taken));
    assert (!pend_redirect || pend_pc == next_pc)
      else abort_run($sformatf("Fail at %0t: redirect to %h, expected %h",
                               $time, pend_pc, next_pc));
    if (exp_rd != 5'd0) begin
      model_regs[exp_rd] = exp_data;
    end
    pend_redirect = 1'b0;
    model_pc      = next_pc;
  endtask

  initial begin
    logic        do_retire;
    logic        do_redir;
    logic        do_acc;
    logic [31:0] r_pc;
    logic [4:0]  r_rd;
    logic [31:0] r_data;
    logic [31:0] r_redir_pc;
    logic [31:0] fetch_pc;
    logic [31:0] word;
    int          retired;
    int          idle;
    seed          = 37794;
    arst_n_i      = 1'b0;
    inst_valid_i  = 1'b0;
    inst_i        = '0;
    pc_i          = '0;
    bpu_taken_i   = 1'b0;
    wb_stall_i    = 1'b0;
    model_pc      = '0;
    pend_redirect = 1'b0;
    pend_pc       = '0;
    fetch_pc      = '0;
    retired       = 0;
    idle          = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    build_program();

    repeat (2) @(posedge clk);
    #1 arst_n_i = 1'b1;

    while (retired < RETIRE_TARGET) begin
      // outputs are settled by the falling edge
      @(negedge clk);
      do_retire  = wb_valid_o && !wb_stall_i;
      r_pc       = wb_pc_o;
      r_rd       = wb_rd_o;
      r_data     = wb_data_o;
      do_redir   = redirect_valid_o && !wb_stall_i;
      r_redir_pc = redirect_pc_o;
      do_acc     = inst_valid_i && ready_o;
      @(posedge clk);
      #1;
      if (do_retire) begin
        check_retire(r_pc, r_rd, r_data);
        retired++;
        idle = 0;
      end else begin
        idle++;
        if (idle > IDLE_LIMIT) begin
          abort_run("timeout: the core stopped retiring instructions");
        end
      end
      if (do_redir) begin
        // the branch stays in flight while younger entries are flushed
        assert (pred_q.size() > 0)
          else abort_run("a redirect arrived with no instruction in flight");
        while (pred_q.size() > 1) begin
          void'(pred_q.pop_back());
        end
        pend_redirect = 1'b1;
        pend_pc       = r_redir_pc;
        fetch_pc      = r_redir_pc;
        inst_valid_i  = 1'b0;
      end else if (do_acc) begin
        fetch_pc = predicted_next(inst_i, pc_i, bpu_taken_i);
        pred_q.push_back(bpu_taken_i);
        inst_valid_i = 1'b0;
      end
      if (!inst_valid_i && rand_below(4) != 0) begin
        word         = prog[fetch_pc[7:2]];
        inst_valid_i = 1'b1;
        inst_i       = word;
        pc_i         = fetch_pc;
        bpu_taken_i  = (word[6:0] == 7'h63 || word[6:0] == 7'h6f) && (rand_below(2) == 1);
      end
      wb_stall_i = (rand_below(5) == 0);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== core_pipe.f ====
hw/pipe_pkg.sv
hw/regfile.sv
hw/id_stage.sv
hw/id_ex_reg.sv
hw/ex_stage.sv
hw/pipe_ctrl.sv
hw/core_pipe.sv
test/core_pipe_chk.sv
test/core_pipe_tb.sv

// ==== Makefile ====
SRCS := core_pipe.f $(wildcard hw/*.sv) $(wildcard test/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vcore_pipe_tb: $(SRCS)
	verilator --binary --timing --assert -f core_pipe.f --top-module core_pipe_tb -o Vcore_pipe_tb

run: obj_dir/Vcore_pipe_tb
	./obj_dir/Vcore_pipe_tb | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
